//--- rtl/cp0_defs.svh
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// cp0 register numbers as seen by mtc0/mfc0
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// reset and fixed values
`define CP0_STATUS_RST   32'h1000_0000 // cu0 set, interrupts off
`define CP0_CONFIG_VAL   32'h0000_8000 // big endian
`define CP0_PRID_VAL     32'h004c_0102

// single entry point for all exceptions and interrupts
`define CP0_EXC_VECTOR   32'h0000_0020

`endif

//--- rtl/cp0_pkg.sv
package cp0_pkg;

    // one pipeline stage's pending mtc0
    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } cp0_wr_t;

    typedef struct packed {
        logic [2:0]  rsvd_31_29;
        logic        cu0;        // cp0 usable
        logic [11:0] rsvd_27_16;
        logic [7:0]  im;         // interrupt mask
        logic [5:0]  rsvd_7_2;
        logic        exl;        // exception level
        logic        ie;         // global interrupt enable
    } status_t;

    typedef struct packed {
        logic        bd;         // last exception in delay slot
        logic [6:0]  rsvd_30_24;
        logic        iv;
        logic        wp;
        logic [5:0]  rsvd_21_16;
        logic [5:0]  ip_hw;      // hardware interrupts, sampled
        logic [1:0]  ip_sw;      // software interrupts, writable
        logic        rsvd_7;
        logic [4:0]  exc_code;
        logic [1:0]  rsvd_1_0;
    } cause_t;

    // a written word, seen raw or as one of the register layouts
    typedef union packed {
        logic [31:0] raw;
        status_t     status;
        cause_t      cause;
    } cp0_word_u;

    // forwarded view used by exception logic
    typedef struct packed {
        status_t     status;
        cause_t      cause;
        logic [31:0] epc;
    } cp0_state_t;

endpackage

//--- rtl/exc_pkg.sv
package exc_pkg;

    // raw flags carried by the instruction in mem
    typedef struct packed {
        logic syscall;
        logic invalid_inst;
        logic trap;
        logic overflow;
        logic eret;
    } exc_flags_t;

    // arbitrated result
    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_INT,
        EXC_SYSCALL,
        EXC_INVALID,
        EXC_TRAP,
        EXC_OVERFLOW,
        EXC_ERET
    } exc_type_e;

    // value stored into cause.exc_code
    typedef enum logic [4:0] {
        EXCCODE_INT = 5'd0,
        EXCCODE_SYS = 5'd8,
        EXCCODE_RI  = 5'd10,
        EXCCODE_OV  = 5'd12,
        EXCCODE_TR  = 5'd13
    } exc_code_e;

    typedef struct packed {
        exc_flags_t  flags;
        logic        in_delayslot;
        logic [31:0] inst_addr;
    } mem_exc_t;

endpackage

//--- rtl/cp0_timer.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module cp0_timer (
    input  logic              clk,
    input  logic              arst_n_i,
    input  cp0_pkg::cp0_wr_t  wb_wr_i,
    output logic [31:0]       count_o,
    output logic [31:0]       compare_o,
    output logic              timer_int_o
);

    logic wr_count;
    logic wr_compare;
    logic match;

    assign wr_count   = wb_wr_i.we && (wb_wr_i.waddr == `CP0_REG_COUNT);
    assign wr_compare = wb_wr_i.we && (wb_wr_i.waddr == `CP0_REG_COMPARE);
    assign match      = (compare_o != 32'd0) && (count_o == compare_o); // zero compare disarms

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_o     <= 32'd0;
            compare_o   <= 32'd0;
            timer_int_o <= 1'b0;
        end else begin
            if (wr_count) begin
                count_o <= wb_wr_i.wdata; // write wins over increment
            end else begin
                count_o <= count_o + 32'd1;
            end

            // interrupt is sticky until software rewrites compare
            if (wr_compare) begin
                compare_o   <= wb_wr_i.wdata;
                timer_int_o <= 1'b0;
            end else if (match) begin
                timer_int_o <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/cp0_regs.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module cp0_regs (
    input  logic                clk,
    input  logic                arst_n_i,
    input  cp0_pkg::cp0_wr_t    wb_wr_i,
    input  logic [5:0]          int_i,
    input  logic                timer_int_i,
    input  exc_pkg::exc_type_e  exc_type_i,
    input  logic                in_delayslot_i,
    input  logic [31:0]         inst_addr_i,
    output cp0_pkg::status_t    status_o,
    output cp0_pkg::cause_t     cause_o,
    output logic [31:0]         epc_o,
    output logic [31:0]         config_o,
    output logic [31:0]         prid_o
);

    cp0_pkg::cp0_word_u  wr_word;
    exc_pkg::exc_code_e  exc_code;
    logic                is_exc;
    logic                rec_epc;
    logic [31:0]         exc_epc;

    assign wr_word.raw = wb_wr_i.wdata;

    // read-only identification registers
    assign config_o = `CP0_CONFIG_VAL;
    assign prid_o   = `CP0_PRID_VAL;

    assign is_exc  = (exc_type_i != exc_pkg::EXC_NONE) && (exc_type_i != exc_pkg::EXC_ERET);
    // a nested exception keeps the first epc, interrupts always record
    assign rec_epc = is_exc && (!status_o.exl || (exc_type_i == exc_pkg::EXC_INT));
    assign exc_epc = in_delayslot_i ? (inst_addr_i - 32'd4) : inst_addr_i; // point at the branch

    always_comb begin
        case (exc_type_i)
            exc_pkg::EXC_SYSCALL:  exc_code = exc_pkg::EXCCODE_SYS;
            exc_pkg::EXC_INVALID:  exc_code = exc_pkg::EXCCODE_RI;
            exc_pkg::EXC_TRAP:     exc_code = exc_pkg::EXCCODE_TR;
            exc_pkg::EXC_OVERFLOW: exc_code = exc_pkg::EXCCODE_OV;
            default:               exc_code = exc_pkg::EXCCODE_INT;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_o <= `CP0_STATUS_RST;
            cause_o  <= '0;
            epc_o    <= 32'd0;
        end else begin
            // timer shares the top hardware line
            cause_o.ip_hw <= {int_i[5] | timer_int_i, int_i[4:0]};

            if (wb_wr_i.we) begin
                case (wb_wr_i.waddr)
                    `CP0_REG_STATUS: status_o <= wr_word.status;
                    `CP0_REG_CAUSE: begin
                        cause_o.ip_sw <= wr_word.cause.ip_sw; // only sw bits, iv, wp
                        cause_o.iv    <= wr_word.cause.iv;
                        cause_o.wp    <= wr_word.cause.wp;
                    end
                    `CP0_REG_EPC:    epc_o <= wr_word.raw;
                    default: ;
                endcase
            end

            // exception recording comes last so it overrides mtc0
            if (is_exc) begin
                cause_o.exc_code <= exc_code;
                status_o.exl     <= 1'b1;
            end
            if (rec_epc) begin
                epc_o      <= exc_epc;
                cause_o.bd <= in_delayslot_i;
            end
            if (exc_type_i == exc_pkg::EXC_ERET) begin
                status_o.exl <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/cp0_read_fwd.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module cp0_read_fwd (
    input  logic [4:0]            raddr_i,
    input  cp0_pkg::cp0_wr_t      mem_wr_i,
    input  cp0_pkg::cp0_wr_t      wb_wr_i,
    input  logic [31:0]           count_i,
    input  logic [31:0]           compare_i,
    input  logic [31:0]           epc_i,
    input  logic [31:0]           config_i,
    input  logic [31:0]           prid_i,
    input  cp0_pkg::status_t      status_i,
    input  cp0_pkg::cause_t       cause_i,
    output logic [31:0]           rdata_o,
    output cp0_pkg::cp0_state_t   fwd_state_o
);

    cp0_pkg::cp0_word_u  status_w;
    cp0_pkg::cp0_word_u  cause_w;
    cp0_pkg::cause_t     cause_m;

    // newest pending write to addr, mem is younger than wb
    function automatic logic [31:0] newest(
        input logic [4:0]        addr,
        input cp0_pkg::cp0_wr_t  mem_wr,
        input cp0_pkg::cp0_wr_t  wb_wr,
        input logic [31:0]       stored
    );
        logic [31:0] val;
        val = stored;
        if (mem_wr.we && (mem_wr.waddr == addr)) begin
            val = mem_wr.wdata;
        end else if (wb_wr.we && (wb_wr.waddr == addr)) begin
            val = wb_wr.wdata;
        end
        return val;
    endfunction

    always_comb begin
        status_w.raw = newest(`CP0_REG_STATUS, mem_wr_i, wb_wr_i, status_i);
        cause_w.raw  = newest(`CP0_REG_CAUSE, mem_wr_i, wb_wr_i, cause_i);

        cause_m       = cause_i; // hw ip, bd and code stay from storage
        cause_m.ip_sw = cause_w.cause.ip_sw;
        cause_m.iv    = cause_w.cause.iv;
        cause_m.wp    = cause_w.cause.wp;

        fwd_state_o.status = status_w.status;
        fwd_state_o.cause  = cause_m;
        fwd_state_o.epc    = newest(`CP0_REG_EPC, mem_wr_i, wb_wr_i, epc_i);
    end

    always_comb begin
        case (raddr_i)
            `CP0_REG_COUNT:   rdata_o = newest(`CP0_REG_COUNT, mem_wr_i, wb_wr_i, count_i);
            `CP0_REG_COMPARE: rdata_o = newest(`CP0_REG_COMPARE, mem_wr_i, wb_wr_i, compare_i);
            `CP0_REG_STATUS:  rdata_o = fwd_state_o.status;
            `CP0_REG_CAUSE:   rdata_o = fwd_state_o.cause;
            `CP0_REG_EPC:     rdata_o = fwd_state_o.epc;
            `CP0_REG_CONFIG:  rdata_o = config_i; // read only
            `CP0_REG_PRID:    rdata_o = prid_i;
            default:          rdata_o = 32'd0;
        endcase
    end

endmodule

//--- rtl/exc_detect.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module exc_detect (
    input  exc_pkg::mem_exc_t     mem_exc_i,
    input  cp0_pkg::cp0_state_t   state_i,
    output exc_pkg::exc_type_e    exc_type_o,
    output logic                  flush_o,
    output logic [31:0]           new_pc_o
);

    logic [7:0] ip;
    logic       int_req;

    assign ip      = {state_i.cause.ip_hw, state_i.cause.ip_sw};
    assign int_req = state_i.status.ie && !state_i.status.exl && |(ip & state_i.status.im);

    // fixed priority, interrupt first
    always_comb begin
        if (int_req) begin
            exc_type_o = exc_pkg::EXC_INT;
        end else if (mem_exc_i.flags.syscall) begin
            exc_type_o = exc_pkg::EXC_SYSCALL;
        end else if (mem_exc_i.flags.invalid_inst) begin
            exc_type_o = exc_pkg::EXC_INVALID;
        end else if (mem_exc_i.flags.trap) begin
            exc_type_o = exc_pkg::EXC_TRAP;
        end else if (mem_exc_i.flags.overflow) begin
            exc_type_o = exc_pkg::EXC_OVERFLOW;
        end else if (mem_exc_i.flags.eret) begin
            exc_type_o = exc_pkg::EXC_ERET;
        end else begin
            exc_type_o = exc_pkg::EXC_NONE;
        end
    end

    assign flush_o = (exc_type_o != exc_pkg::EXC_NONE);

    always_comb begin
        case (exc_type_o)
            exc_pkg::EXC_NONE: new_pc_o = 32'd0;
            exc_pkg::EXC_ERET: new_pc_o = state_i.epc; // includes pending mtc0 epc
            default:           new_pc_o = `CP0_EXC_VECTOR;
        endcase
    end

endmodule

//--- rtl/cp0_subsys.sv
`timescale 1ns/100ps

module cp0_subsys (
    input  logic                clk,
    input  logic                arst_n_i,
    input  cp0_pkg::cp0_wr_t    mem_wr_i,
    input  cp0_pkg::cp0_wr_t    wb_wr_i,
    input  logic [5:0]          int_i,
    input  logic [4:0]          raddr_i,
    input  exc_pkg::mem_exc_t   mem_exc_i,
    output logic [31:0]         rdata_o,
    output logic                timer_int_o,
    output exc_pkg::exc_type_e  exc_type_o,
    output logic                flush_o,
    output logic [31:0]         new_pc_o
);

    logic [31:0]          count;
    logic [31:0]          compare;
    logic                 timer_int;
    cp0_pkg::status_t     status;
    cp0_pkg::cause_t      cause;
    logic [31:0]          epc;
    logic [31:0]          config_val;
    logic [31:0]          prid;
    cp0_pkg::cp0_state_t  fwd_state;
    exc_pkg::exc_type_e   exc_type;

    assign timer_int_o = timer_int;
    assign exc_type_o  = exc_type;

    cp0_timer u_timer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wb_wr_i     (wb_wr_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int)
    );

    cp0_regs u_regs (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .wb_wr_i        (wb_wr_i),
        .int_i          (int_i),
        .timer_int_i    (timer_int),
        .exc_type_i     (exc_type),
        .in_delayslot_i (mem_exc_i.in_delayslot),
        .inst_addr_i    (mem_exc_i.inst_addr),
        .status_o       (status),
        .cause_o        (cause),
        .epc_o          (epc),
        .config_o       (config_val),
        .prid_o         (prid)
    );

    cp0_read_fwd u_fwd (
        .raddr_i     (raddr_i),
        .mem_wr_i    (mem_wr_i),
        .wb_wr_i     (wb_wr_i),
        .count_i     (count),
        .compare_i   (compare),
        .epc_i       (epc),
        .config_i    (config_val),
        .prid_i      (prid),
        .status_i    (status),
        .cause_i     (cause),
        .rdata_o     (rdata_o),
        .fwd_state_o (fwd_state)
    );

    exc_detect u_exc (
        .mem_exc_i  (mem_exc_i),
        .state_i    (fwd_state),
        .exc_type_o (exc_type),
        .flush_o    (flush_o),
        .new_pc_o   (new_pc_o)
    );

endmodule

//--- sim/cp0_subsys_chk.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module cp0_subsys_chk (
    input  logic                clk,
    input  logic                arst_n_i,
    input  cp0_pkg::cp0_wr_t    wb_wr_i,
    input  logic                timer_int_i,
    input  exc_pkg::exc_type_e  exc_type_i,
    input  logic                flush_i,
    input  logic [31:0]         new_pc_i
);

    int unsigned fail_cnt = 0; // failed assertion count
    logic        wr_compare;

    assign wr_compare = wb_wr_i.we && (wb_wr_i.waddr == `CP0_REG_COMPARE);

    flush_matches_type: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i == (exc_type_i != exc_pkg::EXC_NONE))
    else begin
        $error("flush_o disagrees with exc_type_o");
        fail_cnt++;
    end

    // compare write clears the sticky interrupt at its own edge
    compare_write_clears: assert property (@(posedge clk) disable iff (!arst_n_i)
        wr_compare |=> !timer_int_i)
    else begin
        $error("timer_int_o high in the cycle after a compare write");
        fail_cnt++;
    end

    vector_on_exception: assert property (@(posedge clk) disable iff (!arst_n_i)
        (flush_i && (exc_type_i != exc_pkg::EXC_ERET)) |-> (new_pc_i == `CP0_EXC_VECTOR))
    else begin
        $error("new_pc_o is not the exception vector on a flush");
        fail_cnt++;
    end

endmodule

bind cp0_subsys cp0_subsys_chk chk0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .wb_wr_i     (wb_wr_i),
    .timer_int_i (timer_int_o),
    .exc_type_i  (exc_type_o),
    .flush_i     (flush_o),
    .new_pc_i    (new_pc_o)
);

//--- sim/tb_cp0_subsys.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module tb_cp0_subsys;

    localparam int CLK_PERIOD  = 4;
    localparam int TEST_CYCLES = 8 + 200 + 200 + 80 + 300 + 300; // reset, phases, timer budget

    typedef struct packed {
        logic [31:0]       count;
        logic [31:0]       compare;
        logic              tint;
        cp0_pkg::status_t  status;
        cp0_pkg::cause_t   cause;
        logic [31:0]       epc;
    } ref_state_t;

    typedef struct packed {
        logic [31:0]         rdata;
        exc_pkg::exc_type_e  exc;
        logic                flush;
        logic [31:0]         pc;
    } ref_out_t;

    logic                clk;
    logic                arst_n_i;
    cp0_pkg::cp0_wr_t    mem_wr;
    cp0_pkg::cp0_wr_t    wb_wr;
    logic [5:0]          int_lines;
    logic [4:0]          raddr;
    exc_pkg::mem_exc_t   mem_exc;
    logic [31:0]         rdata;
    logic                timer_int;
    exc_pkg::exc_type_e  exc_type;
    logic                flush;
    logic [31:0]         new_pc;
    integer              seed;
    ref_state_t          ref_st;
    ref_out_t            exp_out;
    logic                seen;

    cp0_subsys dut0 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .mem_wr_i    (mem_wr),
        .wb_wr_i     (wb_wr),
        .int_i       (int_lines),
        .raddr_i     (raddr),
        .mem_exc_i   (mem_exc),
        .rdata_o     (rdata),
        .timer_int_o (timer_int),
        .exc_type_o  (exc_type),
        .flush_o     (flush),
        .new_pc_o    (new_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_exc(input exc_pkg::exc_type_e got, input exc_pkg::exc_type_e exp,
                             input logic [31:0] got_pc, input logic [31:0] exp_pc);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: exc_type_o got %s expected %s", $time,
                     got.name(), exp.name());
            stop_on_failure();
        end
        if ((exp != exc_pkg::EXC_NONE) && (got_pc !== exp_pc)) begin // pc only on a flush
            $display("Mismatch at %0t ns: new_pc_o got %h expected %h", $time, got_pc, exp_pc);
            stop_on_failure();
        end
    endtask

    // newest value of a register including writes still in the pipe
    function automatic logic [31:0] pending(input logic [4:0] addr, input logic [31:0] stored);
        if (mem_wr.we && (mem_wr.waddr == addr)) return mem_wr.wdata;
        if (wb_wr.we && (wb_wr.waddr == addr)) return wb_wr.wdata;
        return stored;
    endfunction

    function automatic ref_out_t model_outputs(input ref_state_t s);
        ref_out_t          o;
        cp0_pkg::status_t  st;
        cp0_pkg::cause_t   ca;
        cp0_pkg::cause_t   cw;
        logic [31:0]       epc;
        logic              irq;
        st       = pending(`CP0_REG_STATUS, s.status);
        cw       = pending(`CP0_REG_CAUSE, s.cause);
        ca       = s.cause;
        ca.ip_sw = cw.ip_sw; // only writable fields forward
        ca.iv    = cw.iv;
        ca.wp    = cw.wp;
        epc      = pending(`CP0_REG_EPC, s.epc);
        case (raddr)
            `CP0_REG_COUNT:   o.rdata = pending(`CP0_REG_COUNT, s.count);
            `CP0_REG_COMPARE: o.rdata = pending(`CP0_REG_COMPARE, s.compare);
            `CP0_REG_STATUS:  o.rdata = st;
            `CP0_REG_CAUSE:   o.rdata = ca;
            `CP0_REG_EPC:     o.rdata = epc;
            `CP0_REG_CONFIG:  o.rdata = `CP0_CONFIG_VAL;
            `CP0_REG_PRID:    o.rdata = `CP0_PRID_VAL;
            default:          o.rdata = 32'd0;
        endcase
        irq = st.ie && !st.exl && (({ca.ip_hw, ca.ip_sw} & st.im) != 8'd0);
        if (irq) o.exc = exc_pkg::EXC_INT;
        else if (mem_exc.flags.syscall) o.exc = exc_pkg::EXC_SYSCALL;
        else if (mem_exc.flags.invalid_inst) o.exc = exc_pkg::EXC_INVALID;
        else if (mem_exc.flags.trap) o.exc = exc_pkg::EXC_TRAP;
        else if (mem_exc.flags.overflow) o.exc = exc_pkg::EXC_OVERFLOW;
        else if (mem_exc.flags.eret) o.exc = exc_pkg::EXC_ERET;
        else o.exc = exc_pkg::EXC_NONE;
        o.flush = (o.exc != exc_pkg::EXC_NONE);
        o.pc    = (o.exc == exc_pkg::EXC_ERET) ? epc : `CP0_EXC_VECTOR;
        return o;
    endfunction

    function automatic ref_state_t model_step(input ref_state_t s, input exc_pkg::exc_type_e exc);
        ref_state_t       n;
        cp0_pkg::cause_t  wc;
        n  = s;
        wc = wb_wr.wdata;
        n.count = s.count + 32'd1;
        if ((s.compare != 32'd0) && (s.count == s.compare)) n.tint = 1'b1;
        n.cause.ip_hw = {int_lines[5] | s.tint, int_lines[4:0]};
        if (wb_wr.we) begin
            case (wb_wr.waddr)
                `CP0_REG_COUNT:   n.count = wb_wr.wdata;
                `CP0_REG_COMPARE: begin
                    n.compare = wb_wr.wdata;
                    n.tint    = 1'b0;
                end
                `CP0_REG_STATUS:  n.status = wb_wr.wdata;
                `CP0_REG_CAUSE:   begin
                    n.cause.ip_sw = wc.ip_sw;
                    n.cause.iv    = wc.iv;
                    n.cause.wp    = wc.wp;
                end
                `CP0_REG_EPC:     n.epc = wb_wr.wdata;
                default: ;
            endcase
        end
        if ((exc != exc_pkg::EXC_NONE) && (exc != exc_pkg::EXC_ERET)) begin
            n.status.exl = 1'b1;
            case (exc)
                exc_pkg::EXC_SYSCALL:  n.cause.exc_code = 5'd8;
                exc_pkg::EXC_INVALID:  n.cause.exc_code = 5'd10;
                exc_pkg::EXC_TRAP:     n.cause.exc_code = 5'd13;
                exc_pkg::EXC_OVERFLOW: n.cause.exc_code = 5'd12;
                default:               n.cause.exc_code = 5'd0;
            endcase
            if (!s.status.exl || (exc == exc_pkg::EXC_INT)) begin
                n.epc      = mem_exc.in_delayslot ? mem_exc.inst_addr - 32'd4 : mem_exc.inst_addr;
                n.cause.bd = mem_exc.in_delayslot;
            end
        end else if (exc == exc_pkg::EXC_ERET) begin
            n.status.exl = 1'b0;
        end
        return n;
    endfunction

    function automatic logic roll(input int pct);
        int unsigned r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    function automatic logic [4:0] pick_addr();
        logic [2:0] k;
        k = $random(seed);
        case (k)
            3'd0:    return `CP0_REG_COUNT;
            3'd1:    return `CP0_REG_COMPARE;
            3'd2:    return `CP0_REG_STATUS;
            3'd3:    return `CP0_REG_CAUSE;
            3'd4:    return `CP0_REG_EPC;
            3'd5:    return `CP0_REG_PRID;
            3'd6:    return `CP0_REG_CONFIG;
            default: return 5'd3; // unmapped
        endcase
    endfunction

    task automatic drive_idle();
        mem_wr    = '0;
        wb_wr     = '0;
        mem_exc   = '0;
        int_lines = 6'd0;
        raddr     = `CP0_REG_COUNT;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        drive_idle();
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        drive_idle();
        wb_wr.we    = 1'b1;
        wb_wr.waddr = addr;
        wb_wr.wdata = data;
    endtask

    task automatic run_random(input int cycles, input int wr_pct, input int mem_pct,
                              input int exc_pct, input int int_pct);
        logic [31:0] rnd;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            drive_idle();
            wb_wr.we     = roll(wr_pct);
            wb_wr.waddr  = pick_addr();
            wb_wr.wdata  = $random(seed);
            mem_wr.we    = roll(mem_pct);
            mem_wr.waddr = pick_addr();
            mem_wr.wdata = $random(seed);
            raddr        = pick_addr();
            if (mem_wr.we && roll(40)) raddr = mem_wr.waddr;
            else if (wb_wr.we && roll(40)) raddr = wb_wr.waddr;
            if (roll(exc_pct)) mem_exc.flags = $random(seed);
            mem_exc.in_delayslot = $random(seed);
            rnd                  = $random(seed);
            mem_exc.inst_addr    = {rnd[31:2], 2'b00};
            if (roll(int_pct)) int_lines = $random(seed);
        end
    endtask

    // reference runs alongside the DUT and checks every edge
    always @(posedge clk) begin
        if (arst_n_i) begin
            exp_out = model_outputs(ref_st);
            check_word("rdata_o", rdata, exp_out.rdata);
            check_exc(exc_type, exp_out.exc, new_pc, exp_out.pc);
            check_bit("flush_o", flush, exp_out.flush);
            check_bit("timer_int_o", timer_int, ref_st.tint);
            ref_st = model_step(ref_st, exp_out.exc);
        end
    end

    initial begin
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired, the simulation ran longer than expected");
        stop_on_failure();
    end

    initial begin
        seed           = 32'hcc70;
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        drive_idle();
        ref_st         = '0;
        ref_st.status  = `CP0_STATUS_RST;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        run_random(200, 70, 0, 0, 0);    // mtc0 then mfc0
        run_random(200, 60, 60, 0, 0);   // mem/wb forwarding

        // unmask only the timer line so its interrupt gets taken
        write_reg(`CP0_REG_STATUS, `CP0_STATUS_RST | 32'h0000_8001); // im7 and ie, exl clear
        write_reg(`CP0_REG_COMPARE, ref_st.count + 32'd10);
        seen = 1'b0;
        for (int i = 0; (i < 40) && !seen; i++) begin
            idle_cycle();
            seen = timer_int;
        end
        if (!seen) begin
            $display("timer interrupt never rose after count reached compare");
            stop_on_failure();
        end
        repeat (5) begin
            idle_cycle();
            raddr = `CP0_REG_CAUSE; // ip_hw[5] carries the timer
        end
        check_bit("timer_int_o held", timer_int, 1'b1);
        write_reg(`CP0_REG_COMPARE, 32'd0);
        write_reg(`CP0_REG_COUNT, 32'hffff_fff8); // count wraps through zero
        repeat (20) idle_cycle();
        check_bit("timer_int_o with compare zero", timer_int, 1'b0);

        run_random(300, 30, 20, 40, 0);  // synchronous exceptions
        run_random(300, 30, 10, 20, 30); // interrupts and eret
        repeat (2) idle_cycle();

        if (dut0.chk0.fail_cnt != 0) begin
            $display("assertion checker reported %0d failures", dut0.chk0.fail_cnt);
            $display("tests failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+rtl
rtl/cp0_pkg.sv
rtl/exc_pkg.sv
rtl/cp0_timer.sv
rtl/cp0_regs.sv
rtl/cp0_read_fwd.sv
rtl/exc_detect.sv
rtl/cp0_subsys.sv
sim/cp0_subsys_chk.sv
sim/tb_cp0_subsys.sv
